// ==== host_llc_cfg.f ====
rtl/llc_cfg_pkg.sv
rtl/wb_cfg_slave.sv
rtl/llc_cfg_regs.sv
rtl/llc_event_counters.sv
rtl/llc_region_classifier.sv
rtl/host_llc_cfg_top.sv
verif/host_llc_cfg_assertions.sv
verif/tb_host_llc_cfg.sv

// ==== rtl/host_llc_cfg_top.sv ====
/*
  Top of the host LLC configuration slice.
  Connects the Wishbone slave to the window registers and the event
  counters, and feeds the programmed windows to the region
  classifier. Only wiring lives here.
*/

`default_nettype none

module host_llc_cfg_top (
  input  wire logic                   clk_i,
  input  wire logic                   rst_i,
  input  wire logic                   wb_cyc_i,
  input  wire logic                   wb_stb_i,
  input  wire logic                   wb_we_i,
  input  wire llc_cfg_pkg::cfg_addr_t wb_adr_i,
  input  wire llc_cfg_pkg::cfg_data_t wb_dat_i,
  output logic                        wb_ack_o,
  output llc_cfg_pkg::cfg_data_t      wb_dat_o,
  input  wire logic                   evt_read_hit_i,
  input  wire logic                   evt_read_miss_i,
  input  wire logic                   evt_write_hit_i,
  input  wire logic                   evt_write_miss_i,
  input  wire logic                   acc_valid_i,
  input  wire llc_cfg_pkg::llc_addr_t acc_addr_i,
  output logic                        region_valid_o,
  output llc_cfg_pkg::region_t        region_o,
  output logic                        doorbell_irq_o,
  output logic                        completion_irq_o
);

  import llc_cfg_pkg::*;

  logic      reg_wr;
  reg_idx_t  reg_idx;
  cfg_data_t reg_wdata;
  logic      regs_rd_hit;
  cfg_data_t regs_rd_data;
  logic      cnt_rd_hit;
  cfg_data_t cnt_rd_data;
  llc_addr_t cache_start;
  llc_addr_t cache_end;
  llc_addr_t spm_start;

  wb_cfg_slave i_wb_cfg_slave (
    .clk_i          ( clk_i        ),
    .rst_i          ( rst_i        ),
    .wb_cyc_i       ( wb_cyc_i     ),
    .wb_stb_i       ( wb_stb_i     ),
    .wb_we_i        ( wb_we_i      ),
    .wb_adr_i       ( wb_adr_i     ),
    .wb_dat_i       ( wb_dat_i     ),
    .wb_ack_o       ( wb_ack_o     ),
    .wb_dat_o       ( wb_dat_o     ),
    .reg_wr_o       ( reg_wr       ),
    .reg_idx_o      ( reg_idx      ),
    .reg_wdata_o    ( reg_wdata    ),
    .regs_rd_hit_i  ( regs_rd_hit  ),
    .regs_rd_data_i ( regs_rd_data ),
    .cnt_rd_hit_i   ( cnt_rd_hit   ),
    .cnt_rd_data_i  ( cnt_rd_data  )
  );

  llc_cfg_regs i_llc_cfg_regs (
    .clk_i            ( clk_i            ),
    .rst_i            ( rst_i            ),
    .reg_wr_i         ( reg_wr           ),
    .reg_idx_i        ( reg_idx          ),
    .reg_wdata_i      ( reg_wdata        ),
    .rd_hit_o         ( regs_rd_hit      ),
    .rd_data_o        ( regs_rd_data     ),
    .cache_start_o    ( cache_start      ),
    .cache_end_o      ( cache_end        ),
    .spm_start_o      ( spm_start        ),
    .doorbell_irq_o   ( doorbell_irq_o   ),
    .completion_irq_o ( completion_irq_o )
  );

  llc_event_counters i_llc_event_counters (
    .clk_i            ( clk_i            ),
    .rst_i            ( rst_i            ),
    .reg_wr_i         ( reg_wr           ),
    .reg_idx_i        ( reg_idx          ),
    .evt_read_hit_i   ( evt_read_hit_i   ),
    .evt_read_miss_i  ( evt_read_miss_i  ),
    .evt_write_hit_i  ( evt_write_hit_i  ),
    .evt_write_miss_i ( evt_write_miss_i ),
    .rd_hit_o         ( cnt_rd_hit       ),
    .rd_data_o        ( cnt_rd_data      )
  );

  llc_region_classifier i_llc_region_classifier (
    .clk_i          ( clk_i          ),
    .rst_i          ( rst_i          ),
    .acc_valid_i    ( acc_valid_i    ),
    .acc_addr_i     ( acc_addr_i     ),
    .cache_start_i  ( cache_start    ),
    .cache_end_i    ( cache_end      ),
    .spm_start_i    ( spm_start      ),
    .region_valid_o ( region_valid_o ),
    .region_o       ( region_o       )
  );

endmodule

`default_nettype wire

// ==== rtl/llc_cfg_pkg.sv ====
/*
  Shared definitions for the LLC configuration slice.
  Holds the bus and address widths, the register word indices,
  the region codes and the fixed read word for unmapped offsets.
  Modules import it inside their body and use scoped names in ports.
*/

`default_nettype none

package llc_cfg_pkg;

  typedef logic [31:0] cfg_data_t;
  typedef logic [31:0] cfg_addr_t;
  typedef logic [31:0] llc_addr_t;
  typedef logic [31:0] counter_t;
  // Word index, byte address bits 7 to 2
  typedef logic [5:0]  reg_idx_t;
  typedef logic [1:0]  region_t;

  localparam region_t REGION_BYPASS = 2'd0;
  localparam region_t REGION_CACHED = 2'd1;
  localparam region_t REGION_SPM    = 2'd2;

  // Window and mailbox registers
  localparam reg_idx_t IDX_CACHE_START = 6'h00;
  localparam reg_idx_t IDX_CACHE_END   = 6'h01;
  localparam reg_idx_t IDX_SPM_START   = 6'h02;
  localparam reg_idx_t IDX_DOORBELL    = 6'h03;
  localparam reg_idx_t IDX_COMPLETION  = 6'h04;
  localparam reg_idx_t IDX_IRQ_CLEAR   = 6'h05;

  // Event counters
  localparam reg_idx_t IDX_CNT_READ_HIT   = 6'h08;
  localparam reg_idx_t IDX_CNT_READ_MISS  = 6'h09;
  localparam reg_idx_t IDX_CNT_WRITE_HIT  = 6'h0A;
  localparam reg_idx_t IDX_CNT_WRITE_MISS = 6'h0B;
  localparam reg_idx_t IDX_CNT_CLEAR      = 6'h0C;

  localparam int unsigned NUM_EVENTS = 4;

  // Value after reset of every window register and counter
  localparam cfg_data_t CFG_RESET_VALUE = 32'h0000_0000;

  // Same word the stubbed cache config port answers with
  localparam cfg_data_t UNMAPPED_RDATA = 32'hDEAD_F000;

  typedef enum logic {
    WB_IDLE = 1'b0,
    WB_ACK  = 1'b1
  } wb_state_e;

endpackage

`default_nettype wire

// ==== rtl/llc_cfg_regs.sv ====
/*
  Window and mailbox registers of the LLC configuration slice.
  Holds the cached window start and end, the scratchpad start and
  the doorbell and completion interrupt flags. Decodes its own word
  indices for writes and returns hit and data for reads.
*/

`default_nettype none

module llc_cfg_regs (
  input  wire logic                   clk_i,
  input  wire logic                   rst_i,
  input  wire logic                   reg_wr_i,
  input  wire llc_cfg_pkg::reg_idx_t  reg_idx_i,
  input  wire llc_cfg_pkg::cfg_data_t reg_wdata_i,
  output logic                        rd_hit_o,
  output llc_cfg_pkg::cfg_data_t      rd_data_o,
  output llc_cfg_pkg::llc_addr_t      cache_start_o,
  output llc_cfg_pkg::llc_addr_t      cache_end_o,
  output llc_cfg_pkg::llc_addr_t      spm_start_o,
  output logic                        doorbell_irq_o,
  output logic                        completion_irq_o
);

  import llc_cfg_pkg::*;

  llc_addr_t cache_start_q;
  llc_addr_t cache_end_q;
  llc_addr_t spm_start_q;
  logic      doorbell_q;
  logic      completion_q;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      cache_start_q <= CFG_RESET_VALUE;
      cache_end_q   <= CFG_RESET_VALUE;
      spm_start_q   <= CFG_RESET_VALUE;
      doorbell_q    <= 1'b0;
      completion_q  <= 1'b0;
    end else if (reg_wr_i) begin
      case (reg_idx_i)
        IDX_CACHE_START: cache_start_q <= reg_wdata_i;
        IDX_CACHE_END:   cache_end_q   <= reg_wdata_i;
        IDX_SPM_START:   spm_start_q   <= reg_wdata_i;
        // Any value rings the doorbell
        IDX_DOORBELL:    doorbell_q    <= 1'b1;
        IDX_COMPLETION: begin
          doorbell_q   <= 1'b0;
          completion_q <= 1'b1;
        end
        IDX_IRQ_CLEAR:   completion_q  <= 1'b0;
        default: ;
      endcase
    end
  end

  always_comb begin
    rd_hit_o  = 1'b1;
    rd_data_o = '0;
    case (reg_idx_i)
      IDX_CACHE_START: rd_data_o = cache_start_q;
      IDX_CACHE_END:   rd_data_o = cache_end_q;
      IDX_SPM_START:   rd_data_o = spm_start_q;
      IDX_DOORBELL:    rd_data_o = {31'd0, doorbell_q};
      IDX_COMPLETION:  rd_data_o = {31'd0, completion_q};
      // Reads as zero
      IDX_IRQ_CLEAR:   rd_data_o = '0;
      default:         rd_hit_o  = 1'b0;
    endcase
  end

  assign cache_start_o    = cache_start_q;
  assign cache_end_o      = cache_end_q;
  assign spm_start_o      = spm_start_q;
  assign doorbell_irq_o   = doorbell_q;
  assign completion_irq_o = completion_q;

endmodule

`default_nettype wire

// ==== rtl/llc_event_counters.sv ====
/*
  LLC event counters.
  Counts read hit, read miss, write hit and write miss pulses in
  wrapping counters. A write to the clear register zeroes all four
  and wins over an event at the same edge.
*/

`default_nettype none

module llc_event_counters (
  input  wire logic                  clk_i,
  input  wire logic                  rst_i,
  input  wire logic                  reg_wr_i,
  input  wire llc_cfg_pkg::reg_idx_t reg_idx_i,
  input  wire logic                  evt_read_hit_i,
  input  wire logic                  evt_read_miss_i,
  input  wire logic                  evt_write_hit_i,
  input  wire logic                  evt_write_miss_i,
  output logic                       rd_hit_o,
  output llc_cfg_pkg::cfg_data_t     rd_data_o
);

  import llc_cfg_pkg::*;

  counter_t              cnt_q [NUM_EVENTS];
  logic [NUM_EVENTS-1:0] evt;
  logic                  clear;

  // Order matches the counter register offsets
  assign evt   = {evt_write_miss_i, evt_write_hit_i, evt_read_miss_i, evt_read_hit_i};
  assign clear = reg_wr_i && (reg_idx_i == IDX_CNT_CLEAR);

  always_ff @(posedge clk_i) begin
    for (int i = 0; i < NUM_EVENTS; i++) begin
      if (rst_i || clear) begin
        cnt_q[i] <= CFG_RESET_VALUE;
      end else if (evt[i]) begin
        cnt_q[i] <= cnt_q[i] + 1'b1;
      end
    end
  end

  always_comb begin
    rd_hit_o  = 1'b1;
    rd_data_o = '0;
    case (reg_idx_i)
      IDX_CNT_READ_HIT:   rd_data_o = cnt_q[0];
      IDX_CNT_READ_MISS:  rd_data_o = cnt_q[1];
      IDX_CNT_WRITE_HIT:  rd_data_o = cnt_q[2];
      IDX_CNT_WRITE_MISS: rd_data_o = cnt_q[3];
      IDX_CNT_CLEAR:      rd_data_o = '0;
      default:            rd_hit_o  = 1'b0;
    endcase
  end

endmodule

`default_nettype wire

// ==== rtl/llc_region_classifier.sv ====
/*
  Region classifier for memory accesses.
  Labels each valid address as cached, scratchpad or bypass against
  the programmed windows. One stage: the result appears one cycle
  after the address, one address per cycle, no back-pressure.
*/

`default_nettype none

module llc_region_classifier (
  input  wire logic                   clk_i,
  input  wire logic                   rst_i,
  input  wire logic                   acc_valid_i,
  input  wire llc_cfg_pkg::llc_addr_t acc_addr_i,
  input  wire llc_cfg_pkg::llc_addr_t cache_start_i,
  input  wire llc_cfg_pkg::llc_addr_t cache_end_i,
  input  wire llc_cfg_pkg::llc_addr_t spm_start_i,
  output logic                        region_valid_o,
  output llc_cfg_pkg::region_t        region_o
);

  import llc_cfg_pkg::*;

  logic    in_cached;
  logic    in_spm;
  region_t region_d;

  assign in_cached = (acc_addr_i >= cache_start_i) && (acc_addr_i < cache_end_i);
  // Scratchpad sits below the cached window
  assign in_spm    = (acc_addr_i >= spm_start_i) && (acc_addr_i < cache_start_i);

  always_comb begin
    if (in_cached) begin
      region_d = REGION_CACHED;
    end else if (in_spm) begin
      region_d = REGION_SPM;
    end else begin
      region_d = REGION_BYPASS;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      region_valid_o <= 1'b0;
    end else begin
      region_valid_o <= acc_valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (acc_valid_i) begin
      region_o <= region_d;
    end
  end

endmodule

`default_nettype wire

// ==== rtl/wb_cfg_slave.sv ====
/*
  Wishbone classic slave for the LLC configuration registers.
  Accepts a request from idle, answers with a one-cycle ack and
  never stalls. Writes are strobed to the register owners at the
  accepting edge; read data is chosen by owner hit and registered.
*/

`default_nettype none

module wb_cfg_slave (
  input  wire logic                  clk_i,
  input  wire logic                  rst_i,
  input  wire logic                  wb_cyc_i,
  input  wire logic                  wb_stb_i,
  input  wire logic                  wb_we_i,
  input  wire llc_cfg_pkg::cfg_addr_t wb_adr_i,
  input  wire llc_cfg_pkg::cfg_data_t wb_dat_i,
  output logic                       wb_ack_o,
  output llc_cfg_pkg::cfg_data_t     wb_dat_o,
  output logic                       reg_wr_o,
  output llc_cfg_pkg::reg_idx_t      reg_idx_o,
  output llc_cfg_pkg::cfg_data_t     reg_wdata_o,
  input  wire logic                  regs_rd_hit_i,
  input  wire llc_cfg_pkg::cfg_data_t regs_rd_data_i,
  input  wire logic                  cnt_rd_hit_i,
  input  wire llc_cfg_pkg::cfg_data_t cnt_rd_data_i
);

  import llc_cfg_pkg::*;

  wb_state_e state_q;
  wb_state_e state_d;
  logic      accept;
  cfg_data_t rd_sel;

  assign accept = (state_q == WB_IDLE) && wb_cyc_i && wb_stb_i;

  always_comb begin
    state_d = state_q;
    case (state_q)
      WB_IDLE: if (accept) state_d = WB_ACK;
      // Ack is always a single cycle
      WB_ACK:  state_d = WB_IDLE;
      default: state_d = WB_IDLE;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q <= WB_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  assign wb_ack_o = (state_q == WB_ACK);

  // Write lands in the owner at the accepting edge
  assign reg_wr_o    = accept && wb_we_i;
  assign reg_idx_o   = wb_adr_i[7:2];
  assign reg_wdata_o = wb_dat_i;

  always_comb begin
    if (regs_rd_hit_i) begin
      rd_sel = regs_rd_data_i;
    end else if (cnt_rd_hit_i) begin
      rd_sel = cnt_rd_data_i;
    end else begin
      rd_sel = UNMAPPED_RDATA;
    end
  end

  // Held while ack is high
  always_ff @(posedge clk_i) begin
    if (accept) begin
      wb_dat_o <= rd_sel;
    end
  end

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds the testbench with Verilator and runs it.
# The result is read from sim.log; exit status is nonzero on failure.
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log

verilator --binary --timing --assert --top-module tb_host_llc_cfg \
  -f host_llc_cfg.f -o sim_tb > build.log 2>&1 \
  || { cat build.log; echo "build failed"; exit 1; }

./obj_dir/sim_tb > sim.log 2>&1 || true
cat sim.log

! grep -q "TEST FAIL" sim.log && grep -q "TEST PASS" sim.log \
  && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }

// ==== verif/host_llc_cfg_assertions.sv ====
/*
  Concurrent checks on the Wishbone slave of the LLC slice.
  Bound into every wb_cfg_slave instance; covers the single-cycle
  ack, acks only after an idle-state request, and the write strobe.
*/

`default_nettype none

module host_llc_cfg_assertions (
  input wire logic clk_i,
  input wire logic rst_i,
  input wire logic wb_cyc_i,
  input wire logic wb_stb_i,
  input wire logic wb_we_i,
  input wire logic wb_ack_i,
  input wire logic reg_wr_i
);

  // Slave is idle whenever ack is low
  ack_single_cycle: assert property (
    @(posedge clk_i) disable iff (rst_i)
    wb_ack_i |=> !wb_ack_i
  ) else $error("ack stayed high for more than one cycle");

  ack_after_request: assert property (
    @(posedge clk_i) disable iff (rst_i)
    wb_ack_i |-> $past(wb_cyc_i && wb_stb_i && !wb_ack_i)
  ) else $error("ack without a request from the idle state");

  request_gets_ack: assert property (
    @(posedge clk_i) disable iff (rst_i)
    (wb_cyc_i && wb_stb_i && !wb_ack_i) |=> wb_ack_i
  ) else $error("idle-state request was not acknowledged");

  write_strobe_rule: assert property (
    @(posedge clk_i) disable iff (rst_i)
    reg_wr_i |-> wb_we_i ##1 wb_ack_i
  ) else $error("register write strobe without a write that is acknowledged");

endmodule

bind wb_cfg_slave host_llc_cfg_assertions i_host_llc_cfg_assertions (
  .clk_i    ( clk_i    ),
  .rst_i    ( rst_i    ),
  .wb_cyc_i ( wb_cyc_i ),
  .wb_stb_i ( wb_stb_i ),
  .wb_we_i  ( wb_we_i  ),
  .wb_ack_i ( wb_ack_o ),
  .reg_wr_i ( reg_wr_o )
);

`default_nettype wire

// ==== verif/tb_host_llc_cfg.sv ====
/*
  Testbench for the host LLC configuration slice.
  Drives the Wishbone port, the event pulses and the access stream
  of host_llc_cfg_top through directed tests. Expected values come
  from the register map and the region rules, and every mismatch is
  counted and reported as it happens.
*/

`default_nettype none

module tb_host_llc_cfg;

  import llc_cfg_pkg::*;

  localparam int CLK_PERIOD  = 10;
  localparam int DRIVE_DELAY = 1;
  localparam int ACK_TIMEOUT = 16;

  // Byte offsets of the register map
  localparam logic [31:0] OFS_CACHE_START = 32'h00;
  localparam logic [31:0] OFS_CACHE_END   = 32'h04;
  localparam logic [31:0] OFS_SPM_START   = 32'h08;
  localparam logic [31:0] OFS_DOORBELL    = 32'h0C;
  localparam logic [31:0] OFS_COMPLETION  = 32'h10;
  localparam logic [31:0] OFS_IRQ_CLEAR   = 32'h14;
  localparam logic [31:0] OFS_CNT_RD_HIT  = 32'h20;
  localparam logic [31:0] OFS_CNT_RD_MISS = 32'h24;
  localparam logic [31:0] OFS_CNT_WR_HIT  = 32'h28;
  localparam logic [31:0] OFS_CNT_WR_MISS = 32'h2C;
  localparam logic [31:0] OFS_CNT_CLEAR   = 32'h30;
  localparam logic [31:0] UNMAPPED_WORD   = 32'hDEAD_F000;

  // Windows for the classification test
  localparam logic [31:0] WIN_SPM_START   = 32'h1000_0000;
  localparam logic [31:0] WIN_CACHE_START = 32'h4000_0000;
  localparam logic [31:0] WIN_CACHE_END   = 32'h8000_0000;

  logic        clk_i;
  logic        rst_i;
  logic        wb_cyc_i;
  logic        wb_stb_i;
  logic        wb_we_i;
  logic [31:0] wb_adr_i;
  logic [31:0] wb_dat_i;
  logic        wb_ack_o;
  logic [31:0] wb_dat_o;
  logic        evt_read_hit_i;
  logic        evt_read_miss_i;
  logic        evt_write_hit_i;
  logic        evt_write_miss_i;
  logic        acc_valid_i;
  logic [31:0] acc_addr_i;
  logic        region_valid_o;
  logic [1:0]  region_o;
  logic        doorbell_irq_o;
  logic        completion_irq_o;

  logic [31:0] lcg_state;
  string       test_name;
  int          n_checks;
  int          n_errors;

  host_llc_cfg_top dut0 (
    .clk_i            ( clk_i            ),
    .rst_i            ( rst_i            ),
    .wb_cyc_i         ( wb_cyc_i         ),
    .wb_stb_i         ( wb_stb_i         ),
    .wb_we_i          ( wb_we_i          ),
    .wb_adr_i         ( wb_adr_i         ),
    .wb_dat_i         ( wb_dat_i         ),
    .wb_ack_o         ( wb_ack_o         ),
    .wb_dat_o         ( wb_dat_o         ),
    .evt_read_hit_i   ( evt_read_hit_i   ),
    .evt_read_miss_i  ( evt_read_miss_i  ),
    .evt_write_hit_i  ( evt_write_hit_i  ),
    .evt_write_miss_i ( evt_write_miss_i ),
    .acc_valid_i      ( acc_valid_i      ),
    .acc_addr_i       ( acc_addr_i       ),
    .region_valid_o   ( region_valid_o   ),
    .region_o         ( region_o         ),
    .doorbell_irq_o   ( doorbell_irq_o   ),
    .completion_irq_o ( completion_irq_o )
  );

  initial begin
    clk_i = 1'b0;
    forever begin
      #(CLK_PERIOD / 2);
      clk_i = ~clk_i;
    end
  end

  function automatic logic [31:0] lcg_next(input logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
  endfunction

  // Region rule: cached window first, then scratchpad below it
  function automatic logic [31:0] expected_region(input logic [31:0] addr);
    if (addr >= WIN_CACHE_START && addr < WIN_CACHE_END) begin
      return 32'(REGION_CACHED);
    end else if (addr >= WIN_SPM_START && addr < WIN_CACHE_START) begin
      return 32'(REGION_SPM);
    end
    return 32'(REGION_BYPASS);
  endfunction

  task automatic check(input string what, input logic [31:0] expected,
                       input logic [31:0] actual);
    n_checks++;
    if (actual !== expected) begin
      n_errors++;
      $display("error %s %s expected %h actual %h", test_name, what, expected, actual);
    end
  endtask

  // One classic cycle; starts and ends just after a rising edge
  task automatic wb_access(input logic we, input logic [31:0] adr,
                           input logic [31:0] wdat, output logic [31:0] rdat);
    int waited;
    waited = 0;
    rdat = '0;
    wb_cyc_i = 1'b1;
    wb_stb_i = 1'b1;
    wb_we_i  = we;
    wb_adr_i = adr;
    wb_dat_i = wdat;
    do begin
      @(posedge clk_i);
      #DRIVE_DELAY;
      waited++;
    end while (!wb_ack_o && waited < ACK_TIMEOUT);
    if (wb_ack_o) begin
      rdat = wb_dat_o;
    end else begin
      n_errors++;
      $display("%s no acknowledge from slave for address %h", test_name, adr);
    end
    wb_cyc_i = 1'b0;
    wb_stb_i = 1'b0;
    wb_we_i  = 1'b0;
  endtask

  task automatic wb_write(input logic [31:0] adr, input logic [31:0] wdat);
    logic [31:0] unused_rdat;
    wb_access(1'b1, adr, wdat, unused_rdat);
  endtask

  task automatic wb_read(input logic [31:0] adr, output logic [31:0] rdat);
    wb_access(1'b0, adr, 32'h0, rdat);
  endtask

  task automatic read_and_compare(input string what, input logic [31:0] adr,
                                  input logic [31:0] expected);
    logic [31:0] rdat;
    wb_read(adr, rdat);
    check(what, expected, rdat);
  endtask

  task automatic reset_values();
    test_name = "reset";
    check("doorbell irq", 32'h0, 32'(doorbell_irq_o));
    check("completion irq", 32'h0, 32'(completion_irq_o));
    check("region valid", 32'h0, 32'(region_valid_o));
    read_and_compare("cache start", OFS_CACHE_START, 32'h0);
    read_and_compare("cache end", OFS_CACHE_END, 32'h0);
    read_and_compare("spm start", OFS_SPM_START, 32'h0);
    read_and_compare("read hit count", OFS_CNT_RD_HIT, 32'h0);
    read_and_compare("read miss count", OFS_CNT_RD_MISS, 32'h0);
    read_and_compare("write hit count", OFS_CNT_WR_HIT, 32'h0);
    read_and_compare("write miss count", OFS_CNT_WR_MISS, 32'h0);
  endtask

  task automatic register_readback();
    logic [31:0] values [3];
    test_name = "register map";
    for (int i = 0; i < 3; i++) begin
      lcg_state = lcg_next(lcg_state);
      values[i] = lcg_state;
    end
    wb_write(OFS_CACHE_START, values[0]);
    wb_write(OFS_CACHE_END, values[1]);
    wb_write(OFS_SPM_START, values[2]);
    read_and_compare("cache start", OFS_CACHE_START, values[0]);
    read_and_compare("cache end", OFS_CACHE_END, values[1]);
    read_and_compare("spm start", OFS_SPM_START, values[2]);
    read_and_compare("irq clear", OFS_IRQ_CLEAR, 32'h0);
    read_and_compare("counter clear", OFS_CNT_CLEAR, 32'h0);
    read_and_compare("unmapped 0x18", 32'h18, UNMAPPED_WORD);
    read_and_compare("unmapped 0x40", 32'h40, UNMAPPED_WORD);
  endtask

  task automatic region_classification();
    logic [31:0] addrs [$];
    test_name = "classification";
    wb_write(OFS_CACHE_START, WIN_CACHE_START);
    wb_write(OFS_CACHE_END, WIN_CACHE_END);
    wb_write(OFS_SPM_START, WIN_SPM_START);
    addrs.push_back(WIN_CACHE_START);
    addrs.push_back(WIN_CACHE_END - 32'd1);
    addrs.push_back(WIN_CACHE_END);
    addrs.push_back(WIN_SPM_START);
    for (int i = 0; i < 40; i++) begin
      lcg_state = lcg_next(lcg_state);
      addrs.push_back(lcg_state);
    end
    // One address per cycle, result one cycle later
    foreach (addrs[i]) begin
      acc_valid_i = 1'b1;
      acc_addr_i  = addrs[i];
      @(posedge clk_i);
      #DRIVE_DELAY;
      check("region valid", 32'h1, 32'(region_valid_o));
      check($sformatf("region of %h", addrs[i]), expected_region(addrs[i]), 32'(region_o));
    end
    acc_valid_i = 1'b0;
    @(posedge clk_i);
    #DRIVE_DELAY;
    check("region valid after stream", 32'h0, 32'(region_valid_o));
  endtask

  task automatic event_counting();
    test_name = "event counters";
    for (int i = 0; i < 8; i++) begin
      evt_read_hit_i   = (i < 5);
      evt_read_miss_i  = (i < 3);
      evt_write_hit_i  = (i < 7);
      evt_write_miss_i = (i < 2);
      @(posedge clk_i);
      #DRIVE_DELAY;
    end
    evt_read_hit_i   = 1'b0;
    evt_read_miss_i  = 1'b0;
    evt_write_hit_i  = 1'b0;
    evt_write_miss_i = 1'b0;
    read_and_compare("read hit count", OFS_CNT_RD_HIT, 32'd5);
    read_and_compare("read miss count", OFS_CNT_RD_MISS, 32'd3);
    read_and_compare("write hit count", OFS_CNT_WR_HIT, 32'd7);
    read_and_compare("write miss count", OFS_CNT_WR_MISS, 32'd2);
    wb_write(OFS_CNT_CLEAR, 32'h0);
    read_and_compare("read hit cleared", OFS_CNT_RD_HIT, 32'h0);
    read_and_compare("read miss cleared", OFS_CNT_RD_MISS, 32'h0);
    read_and_compare("write hit cleared", OFS_CNT_WR_HIT, 32'h0);
    read_and_compare("write miss cleared", OFS_CNT_WR_MISS, 32'h0);
  endtask

  task automatic mailbox_flags();
    test_name = "mailbox";
    wb_write(OFS_DOORBELL, 32'h5A5A_0001);
    check("doorbell after ring", 32'h1, 32'(doorbell_irq_o));
    read_and_compare("doorbell readback", OFS_DOORBELL, 32'h1);
    wb_write(OFS_COMPLETION, 32'h0);
    check("doorbell after completion", 32'h0, 32'(doorbell_irq_o));
    check("completion after completion", 32'h1, 32'(completion_irq_o));
    read_and_compare("doorbell readback", OFS_DOORBELL, 32'h0);
    read_and_compare("completion readback", OFS_COMPLETION, 32'h1);
    wb_write(OFS_IRQ_CLEAR, 32'hFFFF_FFFF);
    check("completion after clear", 32'h0, 32'(completion_irq_o));
    read_and_compare("completion readback", OFS_COMPLETION, 32'h0);
  endtask

  initial begin
    rst_i            = 1'b1;
    wb_cyc_i         = 1'b0;
    wb_stb_i         = 1'b0;
    wb_we_i          = 1'b0;
    wb_adr_i         = '0;
    wb_dat_i         = '0;
    evt_read_hit_i   = 1'b0;
    evt_read_miss_i  = 1'b0;
    evt_write_hit_i  = 1'b0;
    evt_write_miss_i = 1'b0;
    // Access valid held high so only reset keeps region valid low
    acc_valid_i      = 1'b1;
    acc_addr_i       = '0;
    lcg_state        = 32'he6cd_e865;
    test_name        = "setup";
    n_checks         = 0;
    n_errors         = 0;
    repeat (16) @(posedge clk_i);
    #DRIVE_DELAY;
    rst_i       = 1'b0;
    acc_valid_i = 1'b0;
    reset_values();
    register_readback();
    region_classification();
    event_counting();
    mailbox_flags();
    $display("checks %0d, errors %0d", n_checks, n_errors);
    if (n_errors == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire
